/* logic/histPkg.sv */
package histPkg;

    // raw code width from the time-to-digital converter
    localparam int TimeBits = 16;

    // one photon arrival time, msbs first
    typedef logic [TimeBits-1:0] timeCodeT;

    // frame controller states
    typedef enum logic [2:0] {
        Clear,   // zero every bin
        Idle,    // wait for the next event
        Read,    // bin count on its way out of the RAM
        Write,   // incremented count goes back
        Scan,    // read all bins in order
        Drain,   // let the last reads reach peakFind
        Report   // result handshake
    } ctrlStateT;

    // top level defaults
    localparam int DefBinBits   = 4;   // 16 bins
    localparam int DefCountBits = 4;   // counts saturate at 15
    localparam int DefFrameLen  = 16;  // events per frame

endpackage

/* logic/histRam.sv */
`timescale 1ns/1ps

// histogram store, one write port and one read port
module histRam import histPkg::*; #(
    parameter int BinBits   = DefBinBits,
    parameter int CountBits = DefCountBits
) (
    input  logic                 clk,
    input  logic                 wEn,
    input  logic [BinBits-1:0]   wAddr,
    input  logic [CountBits-1:0] wData,
    input  logic                 rEn,
    input  logic [BinBits-1:0]   rAddr,
    output logic [CountBits-1:0] rData
);

    localparam int Bins = 1 << BinBits;

    logic [CountBits-1:0] mem [Bins];

    // write side
    always_ff @(posedge clk) begin
        if (wEn) begin
            mem[wAddr] <= wData;
        end
    end

    // registered read, a write to the same address in the
    // same cycle is not seen until the next read
    always_ff @(posedge clk) begin
        if (rEn) begin
            rData <= mem[rAddr];
        end
    end

    // x or out of range write address
    assert property (@(posedge clk) wEn |-> !$isunknown(wAddr) && (int'(wAddr) < Bins))
        else $error("histRam: bad write address %0h", wAddr);

endmodule

/* logic/histControl.sv */
`timescale 1ns/1ps

module histControl import histPkg::*; #(
    parameter int BinBits   = DefBinBits,
    parameter int CountBits = DefCountBits,
    parameter int FrameLen  = DefFrameLen
) (
    input  logic                 clk,
    input  logic                 res,
    // event handshake
    input  logic                 evReq,
    input  timeCodeT             evData,
    output logic                 evAck,
    // result handshake
    output logic                 resReq,
    input  logic                 resAck,
    // RAM ports
    output logic                 wEn,
    output logic [BinBits-1:0]   wAddr,
    output logic [CountBits-1:0] wData,
    output logic                 rEn,
    output logic [BinBits-1:0]   rAddr,
    input  logic [CountBits-1:0] rData,
    // scan stream to peakFind
    output logic                 scanStart,
    output logic                 scanValid,
    output logic [BinBits-1:0]   scanBin
);

    localparam int Bins   = 1 << BinBits;
    localparam int EvBits = (FrameLen > 1) ? $clog2(FrameLen) : 1;

    localparam logic [BinBits-1:0]   LastBin   = BinBits'(Bins - 1);
    localparam logic [EvBits-1:0]    LastEv    = EvBits'(FrameLen - 1);
    localparam logic [CountBits-1:0] FullCount = '1;

    ctrlStateT            state;
    logic [BinBits-1:0]   binCnt;    // clear and scan address
    logic [EvBits-1:0]    evCnt;     // events taken this frame
    logic [1:0]           drainCnt;
    logic [BinBits-1:0]   evBin;     // bin of the event in flight
    logic                 scanRead;  // rEn belongs to the scan
    logic [CountBits-1:0] bumped;

    // saturating increment of the count coming out of the RAM
    assign bumped = (rData == FullCount) ? rData : rData + 1'b1;

    // zeros while clearing, the new count during Write
    assign wData = (state == Write) ? bumped : '0;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= Clear;
            binCnt    <= '0;
            evCnt     <= '0;
            drainCnt  <= '0;
            evBin     <= '0;
            evAck     <= 1'b0;
            resReq    <= 1'b0;
            wEn       <= 1'b0;
            wAddr     <= '0;
            rEn       <= 1'b0;
            rAddr     <= '0;
            scanStart <= 1'b0;
            scanRead  <= 1'b0;
        end else begin
            // single cycle strobes
            wEn       <= 1'b0;
            rEn       <= 1'b0;
            scanStart <= 1'b0;
            scanRead  <= 1'b0;

            if (evAck && !evReq) begin
                evAck <= 1'b0;  // source has let go
            end

            case (state)
                Clear: begin
                    wEn    <= 1'b1;
                    wAddr  <= binCnt;
                    binCnt <= binCnt + 1'b1;  // wraps back to zero for the scan
                    evCnt  <= '0;
                    if (binCnt == LastBin) begin
                        state <= Idle;
                    end
                end

                Idle: begin
                    // a held request from the last event is not a new one
                    if (evReq && !evAck) begin
                        evAck <= 1'b1;
                        rEn   <= 1'b1;
                        rAddr <= evData[TimeBits-1 -: BinBits];
                        evBin <= evData[TimeBits-1 -: BinBits];
                        state <= Read;
                    end
                end

                Read: begin
                    // count arrives during Write, wData follows it
                    wEn   <= 1'b1;
                    wAddr <= evBin;
                    state <= Write;
                end

                Write: begin
                    evCnt <= evCnt + 1'b1;
                    if (evCnt == LastEv) begin
                        scanStart <= 1'b1;
                        state     <= Scan;
                    end else begin
                        state <= Idle;
                    end
                end

                Scan: begin
                    rEn      <= 1'b1;
                    rAddr    <= binCnt;
                    scanRead <= 1'b1;
                    binCnt   <= binCnt + 1'b1;
                    if (binCnt == LastBin) begin
                        drainCnt <= '0;
                        state    <= Drain;
                    end
                end

                Drain: begin
                    // RAM stage, then the peakFind register
                    drainCnt <= drainCnt + 1'b1;
                    if (drainCnt == 2'd2) begin
                        resReq <= 1'b1;
                        state  <= Report;
                    end
                end

                Report: begin
                    if (resReq && resAck) begin
                        resReq <= 1'b0;
                    end else if (!resReq && !resAck) begin
                        binCnt <= '0;
                        state  <= Clear;  // next frame starts from an empty RAM
                    end
                end

                default: state <= Clear;
            endcase
        end
    end

    // valid flag lines up with rData one cycle after rEn
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanValid <= 1'b0;
        end else begin
            scanValid <= scanRead;
        end
    end

    always_ff @(posedge clk) begin
        if (scanRead) begin
            scanBin <= rAddr;
        end
    end

    // ack only answers a request that was up on the previous edge
    assert property (@(posedge clk) disable iff (!res) $rose(evAck) |-> $past(evReq))
        else $error("histControl: evAck rose without evReq");

    // peakFind must hold still while the sink reads the result
    assert property (@(posedge clk) disable iff (!res)
        (state == Report) |-> !scanValid && !scanStart)
        else $error("histControl: scan activity during Report");

    // a write would race the scan reads
    assert property (@(posedge clk) disable iff (!res) (state == Scan) |-> !wEn)
        else $error("histControl: write during Scan");

endmodule

/* logic/peakFind.sv */
`timescale 1ns/1ps

// running max and argmax over the bin stream from the scan
module peakFind import histPkg::*; #(
    parameter int BinBits   = DefBinBits,
    parameter int CountBits = DefCountBits
) (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 scanStart,
    input  logic                 scanValid,
    input  logic [BinBits-1:0]   scanBin,
    input  logic [CountBits-1:0] rData,
    output logic [BinBits-1:0]   peakBin,
    output logic [CountBits-1:0] peakCount
);

    logic newMax;

    // strictly greater, equal counts keep the earlier bin
    assign newMax = scanValid && (rData > peakCount);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakBin   <= '0;
            peakCount <= '0;
        end else if (scanStart) begin
            peakBin   <= '0;   // fresh frame
            peakCount <= '0;
        end else if (newMax) begin
            peakBin   <= scanBin;
            peakCount <= rData;
        end
    end

    // the tie rule relies on bins arriving in ascending order
    assert property (@(posedge clk) disable iff (!res)
        scanValid && $past(scanValid) |-> scanBin == $past(scanBin) + 1'b1)
        else $error("peakFind: bins out of order");

    // a scan always opens with scanStart
    assert property (@(posedge clk) disable iff (!res)
        $rose(scanValid) |-> $past(scanStart, 2))
        else $error("peakFind: scan data without scanStart");

endmodule

/* logic/histTop.sv */
`timescale 1ns/1ps

module histTop import histPkg::*; #(
    parameter int BinBits   = DefBinBits,
    parameter int CountBits = DefCountBits,
    parameter int FrameLen  = DefFrameLen
) (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 evReq,
    input  timeCodeT             evData,
    output logic                 evAck,
    output logic                 resReq,
    output logic [BinBits-1:0]   peakBin,
    output logic [CountBits-1:0] peakCount,
    input  logic                 resAck
);

    // RAM side
    logic                 wEn;
    logic [BinBits-1:0]   wAddr;
    logic [CountBits-1:0] wData;
    logic                 rEn;
    logic [BinBits-1:0]   rAddr;
    logic [CountBits-1:0] rData;

    // scan stream
    logic                 scanStart;
    logic                 scanValid;
    logic [BinBits-1:0]   scanBin;

    histControl #(
        .BinBits   (BinBits),
        .CountBits (CountBits),
        .FrameLen  (FrameLen)
    ) control (
        .clk       (clk),
        .res       (res),
        .evReq     (evReq),
        .evData    (evData),
        .evAck     (evAck),
        .resReq    (resReq),
        .resAck    (resAck),
        .wEn       (wEn),
        .wAddr     (wAddr),
        .wData     (wData),
        .rEn       (rEn),
        .rAddr     (rAddr),
        .rData     (rData),
        .scanStart (scanStart),
        .scanValid (scanValid),
        .scanBin   (scanBin)
    );

    histRam #(
        .BinBits   (BinBits),
        .CountBits (CountBits)
    ) ram (
        .clk   (clk),
        .wEn   (wEn),
        .wAddr (wAddr),
        .wData (wData),
        .rEn   (rEn),
        .rAddr (rAddr),
        .rData (rData)
    );

    peakFind #(
        .BinBits   (BinBits),
        .CountBits (CountBits)
    ) peak (
        .clk       (clk),
        .res       (res),
        .scanStart (scanStart),
        .scanValid (scanValid),
        .scanBin   (scanBin),
        .rData     (rData),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

endmodule

/* verif/histTb.sv */
`timescale 1ns/1ps

module histTb import histPkg::*; ();

    localparam int Bins       = 1 << DefBinBits;
    localparam int MaxCount   = (1 << DefCountBits) - 1;
    localparam int FrameLen   = DefFrameLen;
    localparam int HandFrames = 4;
    localparam int RandFrames = 6;
    localparam int NumFrames  = HandFrames + RandFrames;
    localparam int HandWords  = HandFrames * (FrameLen + 1);
    localparam int MaxDelay   = 64;
    localparam int EvCycles   = 8;   // generous bound for one event handshake

    logic                    clk;
    logic                    res;
    logic                    evReq;
    timeCodeT                evData;
    logic                    evAck;
    logic                    resReq;
    logic [DefBinBits-1:0]   peakBin;
    logic [DefCountBits-1:0] peakCount;
    logic                    resAck;

    timeCodeT    caseWords [0:HandWords-1];
    timeCodeT    allCodes [0:NumFrames*FrameLen-1];
    int          allDelays [0:NumFrames-1];
    int          hist [0:Bins-1];   // reference histogram of one frame
    logic [31:0] rngState;
    int          errCount;
    int          failedFrames;
    int          limitCycles = 0;

    histTop DUT (
        .clk       (clk),
        .res       (res),
        .evReq     (evReq),
        .evData    (evData),
        .evAck     (evAck),
        .resReq    (resReq),
        .peakBin   (peakBin),
        .peakCount (peakCount),
        .resAck    (resAck)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
            errCount++;
        end
    endtask

    // all driving and sampling happens 5 ns after the edge
    task automatic nextCycle();
        @(posedge clk);
        #5;
    endtask

    function automatic string frameName(input int f);
        case (f)
            0:       return "hand, clean start and clear winner";
            1:       return "hand, tie goes to the lower bin";
            2:       return "hand, saturation";
            3:       return "hand, long result back-pressure";
            default: return "random";
        endcase
    endfunction

    task automatic loadFrames();
        int f;
        int i;
        $readmemh("verif/histCases.txt", caseWords);
        for (f = 0; f < HandFrames; f++) begin
            for (i = 0; i < FrameLen; i++) begin
                allCodes[f*FrameLen+i] = caseWords[f*(FrameLen+1)+i];
            end
            allDelays[f] = int'(caseWords[f*(FrameLen+1)+FrameLen]);
            if (allDelays[f] > MaxDelay) begin
                $display("cases file frame %0d asks for a resAck delay of %0d, limit is %0d",
                         f, allDelays[f], MaxDelay);
                errCount++;
                allDelays[f] = MaxDelay;
            end
        end
        rngState = 32'h7e814430;
        for (f = HandFrames; f < NumFrames; f++) begin
            for (i = 0; i < FrameLen; i++) begin
                rngState = xorshift(rngState);
                allCodes[f*FrameLen+i] = rngState[31:16];
            end
            rngState     = xorshift(rngState);
            allDelays[f] = int'(rngState[2:0]);
        end
        // events, clear, scan and drain per frame plus the result wait
        limitCycles = 10;
        for (f = 0; f < NumFrames; f++) begin
            limitCycles += FrameLen * EvCycles + 2 * Bins + 16 + allDelays[f];
        end
    endtask

    task automatic buildModel(input int f, output int expBin, output int expCount);
        int i;
        int b;
        for (b = 0; b < Bins; b++) begin
            hist[b] = 0;
        end
        for (i = 0; i < FrameLen; i++) begin
            b = int'(allCodes[f*FrameLen+i][TimeBits-1 -: DefBinBits]);  // top bits
            if (hist[b] < MaxCount) begin
                hist[b]++;
            end
        end
        expBin   = 0;
        expCount = 0;
        for (b = 0; b < Bins; b++) begin
            if (hist[b] > expCount) begin  // first maximum wins
                expBin   = b;
                expCount = hist[b];
            end
        end
    endtask

    task automatic sendEvent(input timeCodeT code);
        evData = code;
        evReq  = 1'b1;
        nextCycle();
        while (!evAck) begin
            nextCycle();
        end
        evReq = 1'b0;
        nextCycle();
        while (evAck) begin
            nextCycle();
        end
    endtask

    // holds the result for the stored delay and checks it stays at the model's peak
    task automatic holdResult(input int f, input int heldBin, input int heldCount);
        int d;
        if (allDelays[f] > 0 && f + 1 < NumFrames) begin
            evData = allCodes[(f+1)*FrameLen];  // next frame knocks early
            evReq  = 1'b1;
        end
        for (d = 0; d < allDelays[f]; d++) begin
            nextCycle();
            check("resReq", 32'(resReq), 1);
            check("peakBin", 32'(peakBin), heldBin);
            check("peakCount", 32'(peakCount), heldCount);
            check("evAck", 32'(evAck), 0);
        end
        resAck = 1'b1;
        nextCycle();
        while (resReq) begin
            check("peakBin", 32'(peakBin), heldBin);
            check("peakCount", 32'(peakCount), heldCount);
            check("evAck", 32'(evAck), 0);
            nextCycle();
        end
        resAck = 1'b0;
    endtask

    task automatic runFrame(input int f);
        int i;
        int errBefore;
        int expBin;
        int expCount;
        errBefore = errCount;
        buildModel(f, expBin, expCount);
        for (i = 0; i < FrameLen; i++) begin
            sendEvent(allCodes[f*FrameLen+i]);
        end
        while (!resReq) begin
            nextCycle();
        end
        check("peakBin", 32'(peakBin), expBin);
        check("peakCount", 32'(peakCount), expCount);
        holdResult(f, expBin, expCount);
        if (errCount != errBefore) begin
            failedFrames++;
        end
        $display("frame %0d (%s) bin %0d count %0d: %s", f, frameName(f), expBin, expCount,
                 (errCount == errBefore) ? "ok" : "mismatch");
    endtask

    // watchdog
    initial begin
        wait (limitCycles != 0);
        repeat (limitCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT stopped answering", limitCycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int f;
        res          = 1'b0;
        evReq        = 1'b0;
        evData       = '0;
        resAck       = 1'b0;
        errCount     = 0;
        failedFrames = 0;
        loadFrames();
        repeat (4) @(posedge clk);
        #5;
        // outputs quiet while in reset
        check("evAck", 32'(evAck), 0);
        check("resReq", 32'(resReq), 0);
        check("wEn", 32'(DUT.wEn), 0);
        check("rEn", 32'(DUT.rEn), 0);
        res = 1'b1;
        for (f = 0; f < NumFrames; f++) begin
            runFrame(f);
        end
        $display("%0d frames run, %0d failed, %0d mismatches", NumFrames, failedFrames, errCount);
        if (errCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verif/histCases.txt */
// hand frames for histTb, one block per frame
// sixteen hex time codes (top digit is the bin), then the resAck delay in cycles

// clear winner in bin 3, also the first frame after reset
3a10 3b22 7004 3f00
a123 7ff1 0c01 3001
e9e9 a0a0 7333 3999
5555 1234 c0de 2bad
0000

// bins 9 and 4 both reach four, bin 4 must win
9000 4001 9fff 4abc
9123 b000 4777 9876
4321 6000 d111 f0f0
0001 8888 2222 6fff
0003

// all sixteen land in bin c, count stops at 15
c000 c001 c002 c003
c0ff c100 c1ff c200
c7a5 c800 c9c9 caaa
cbbb cccc cddd cfff
0001

// peak of eight in bin f, result held for twelve cycles
ffff f000 0000 0fff
f800 8000 f123 1111
f456 2222 f789 3333
fabc 4444 fdef 5555
000c

/* src.f */
logic/histPkg.sv
logic/histRam.sv
logic/histControl.sv
logic/peakFind.sv
logic/histTop.sv
verif/histTb.sv

/* Makefile */
# Verilator build and run of the histogram testbench

TOP = histTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 -f src.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then echo "run failed, see sim.log"; exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log || (echo "run ended early, see sim.log"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
